/* trace_enc_consts.svh */
// ========================================
// trace encoder constants
// widths and limits shared by the encoder
// ========================================

`ifndef TRACE_ENC_CONSTS_SVH
`define TRACE_ENC_CONSTS_SVH

// instruction address width
`define TRACE_ADDR_W 32

// exception cause width
`define TRACE_CAUSE_W 5

// branch map capacity in branches
`define TRACE_BMAP_LEN 31

// branch count width holds 0 to TRACE_BMAP_LEN
`define TRACE_BCNT_W 5

// packets allowed between two syncs before
// a forced resync
`define TRACE_RESYNC_MAX 7

`endif

/* trace_enc_pkg.sv */
// ========================================
// trace encoder package
// retirement, packet and mode types
// ========================================

`include "trace_enc_consts.svh"

package trace_enc_pkg;

    // one retired instruction from the core
    typedef struct packed {
        logic                      valid;
        logic [`TRACE_ADDR_W-1:0]  iaddr;
        logic                      is_branch;
        logic                      taken;
        logic                      is_exception;
        logic [`TRACE_CAUSE_W-1:0] cause;
    } retire_t;

    // packet formats
    typedef enum logic [1:0] {
        // branch map full
        FMT_BRANCH = 2'b00,
        // exception with cause
        FMT_EXC    = 2'b01,
        // first packet after enable, or forced resync
        FMT_SYNC   = 2'b10
    } packet_format_e;

    // one output packet
    typedef struct packed {
        packet_format_e             format;
        logic [`TRACE_ADDR_W-1:0]   address;
        logic [`TRACE_CAUSE_W-1:0]  cause;
        logic [`TRACE_BCNT_W-1:0]   branches;
        logic [`TRACE_BMAP_LEN-1:0] branch_map;
    } trace_packet_t;

    // what the resync counter counts
    typedef enum logic {
        RESYNC_PACKETS = 1'b0,
        RESYNC_CYCLES  = 1'b1
    } resync_mode_e;

endpackage

/* trace_resync_counter.sv */
// ========================================
// resync counter
// counts packets or cycles since last sync
// ========================================

`timescale 1ns/1ps

`include "trace_enc_consts.svh"

module trace_resync_counter
    import trace_enc_pkg::*;
#(
    parameter resync_mode_e MODE      = RESYNC_PACKETS,
    parameter int unsigned  MAX_VALUE = `TRACE_RESYNC_MAX
) (
    input  logic clk,
    input  logic reset_i,
    input  logic trace_enabled_i,
    input  logic packet_emitted_i,
    input  logic resync_rst_i,
    output logic gt_resync_max_o,
    output logic et_resync_max_o
);

    // room for the saturation point at max plus one
    localparam int unsigned CNT_W = $clog2(MAX_VALUE + 2);
    localparam logic [CNT_W-1:0] MAX_CNT = CNT_W'(MAX_VALUE);
    localparam logic [CNT_W-1:0] SAT_CNT = CNT_W'(MAX_VALUE + 1);

    logic [CNT_W-1:0] count_q;
    logic             incr;

    // cycle mode counts every enabled cycle
    assign incr = (MODE == RESYNC_CYCLES) ? 1'b1 : packet_emitted_i;

    always_ff @(posedge clk) begin
        if (reset_i || !trace_enabled_i) begin
            count_q <= '0;
        end else if (resync_rst_i) begin
            // a sync restarts the distance
            count_q <= '0;
        end else if (incr && (count_q != SAT_CNT)) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign gt_resync_max_o = (count_q > MAX_CNT);
    assign et_resync_max_o = (count_q == MAX_CNT);

    // count stops one past the maximum
    property p_count_bounded;
        @(posedge clk) disable iff (reset_i)
        count_q <= SAT_CNT;
    endproperty

    a_count_bounded: assert property (p_count_bounded)
        else $error("%0t: resync count %0d above %0d", $time, count_q, SAT_CNT);

endmodule

/* trace_branch_map.sv */
// ========================================
// branch map
// collects taken bits of retired branches
// ========================================

`timescale 1ns/1ps

`include "trace_enc_consts.svh"

module trace_branch_map
    import trace_enc_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       trace_enable_i,
    input  retire_t                    retire_i,
    input  logic                       flush_i,
    output logic [`TRACE_BCNT_W-1:0]   count_o,
    output logic [`TRACE_BMAP_LEN-1:0] map_o,
    output logic                       full_next_o
);

    logic [`TRACE_BCNT_W-1:0]   cnt_q;
    logic [`TRACE_BMAP_LEN-1:0] map_q;
    logic [`TRACE_BMAP_LEN-1:0] new_bit;
    logic                       add_bit;

    // a branch retiring while trace is on
    assign add_bit = trace_enable_i && retire_i.valid && retire_i.is_branch;

    // taken bit goes to the next free slot with bit 0 oldest
    always_comb begin
        new_bit    = '0;
        new_bit[0] = add_bit && retire_i.taken;
        new_bit    = new_bit << cnt_q;
    end

    // current instruction already counted
    assign count_o     = cnt_q + `TRACE_BCNT_W'(add_bit);
    assign map_o       = map_q | new_bit;
    assign full_next_o = (count_o == `TRACE_BCNT_W'(`TRACE_BMAP_LEN));

    always_ff @(posedge clk) begin
        if (reset_i || !trace_enable_i || flush_i) begin
            cnt_q <= '0;
            map_q <= '0;
        end else begin
            cnt_q <= count_o;
            map_q <= map_o;
        end
    end

    // a full map has to be drained by a packet in the same cycle
    property p_full_flushed;
        @(posedge clk) disable iff (reset_i)
        full_next_o |-> flush_i;
    endproperty

    a_full_flushed: assert property (p_full_flushed)
        else $error("%0t: branch map full without flush, count %0d", $time, count_o);

endmodule

/* trace_packet_decider.sv */
// ========================================
// packet decider
// picks packet and format per retirement
// ========================================

`timescale 1ns/1ps

module trace_packet_decider
    import trace_enc_pkg::*;
(
    input  logic           clk,
    input  logic           reset_i,
    input  logic           trace_enable_i,
    input  retire_t        retire_i,
    input  logic           resync_due_i,
    input  logic           map_full_i,
    output logic           send_o,
    output packet_format_e fmt_o,
    output logic           sync_sent_o
);

    // set until the first sync after enable
    logic first_q;
    logic retired;

    assign retired = trace_enable_i && retire_i.valid;

    // priority order is first, exception, resync, full map
    always_comb begin
        send_o = 1'b0;
        fmt_o  = FMT_SYNC;
        if (retired) begin
            if (first_q) begin
                send_o = 1'b1;
                fmt_o  = FMT_SYNC;
            end else if (retire_i.is_exception) begin
                send_o = 1'b1;
                fmt_o  = FMT_EXC;
            end else if (resync_due_i) begin
                // too long since the last sync
                send_o = 1'b1;
                fmt_o  = FMT_SYNC;
            end else if (map_full_i) begin
                send_o = 1'b1;
                fmt_o  = FMT_BRANCH;
            end
        end
    end

    assign sync_sent_o = send_o && (fmt_o == FMT_SYNC);

    always_ff @(posedge clk) begin
        if (reset_i || !trace_enable_i) begin
            first_q <= 1'b1;
        end else if (sync_sent_o) begin
            first_q <= 1'b0;
        end
    end

    // packets only come from traced retirements
    property p_send_needs_retire;
        @(posedge clk) disable iff (reset_i)
        send_o |-> (trace_enable_i && retire_i.valid);
    endproperty

    a_send_needs_retire: assert property (p_send_needs_retire)
        else $error("%0t: send_o without valid retirement, enable %b valid %b",
                    $time, trace_enable_i, retire_i.valid);

endmodule

/* trace_packet_emitter.sv */
// ========================================
// packet emitter
// registers packet fields and valid
// ========================================

`timescale 1ns/1ps

`include "trace_enc_consts.svh"

module trace_packet_emitter
    import trace_enc_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       send_i,
    input  packet_format_e             fmt_i,
    input  retire_t                    retire_i,
    input  logic [`TRACE_BCNT_W-1:0]   branches_i,
    input  logic [`TRACE_BMAP_LEN-1:0] branch_map_i,
    output trace_packet_t              packet_o,
    output logic                       packet_valid_o
);

    trace_packet_t packet_d;
    trace_packet_t packet_q;
    logic          valid_q;

    always_comb begin
        packet_d.format     = fmt_i;
        packet_d.address    = retire_i.iaddr;
        // cause only meaningful for exceptions
        packet_d.cause      = (fmt_i == FMT_EXC) ? retire_i.cause : '0;
        packet_d.branches   = branches_i;
        packet_d.branch_map = branch_map_i;
    end

    // payload held until the next packet
    always_ff @(posedge clk) begin
        if (send_i) begin
            packet_q <= packet_d;
        end
    end

    // one-cycle strobe per packet
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= send_i;
        end
    end

    assign packet_o       = packet_q;
    assign packet_valid_o = valid_q;

    // branch count and map agree on the highest used slot
    property p_map_within_count;
        @(posedge clk) disable iff (reset_i)
        valid_q |-> ((packet_q.branch_map >> packet_q.branches) == '0);
    endproperty

    a_map_within_count: assert property (p_map_within_count)
        else $error("%0t: branch_map %h has bits above count %0d",
                    $time, packet_q.branch_map, packet_q.branches);

endmodule

/* trace_encoder_top.sv */
// ========================================
// trace encoder top
// retired instructions to trace packets
// ========================================

`timescale 1ns/1ps

`include "trace_enc_consts.svh"

module trace_encoder_top
    import trace_enc_pkg::*;
(
    input  logic          clk,
    input  logic          reset_i,
    input  logic          trace_enable_i,
    input  retire_t       retire_i,
    output trace_packet_t packet_o,
    output logic          packet_valid_o
);

    logic                       send;
    packet_format_e             fmt;
    logic                       sync_sent;
    logic [`TRACE_BCNT_W-1:0]   bmap_count;
    logic [`TRACE_BMAP_LEN-1:0] bmap_bits;
    logic                       bmap_full_next;
    logic                       gt_max;
    logic                       et_max;

    trace_packet_decider u_decider (
        .clk           (clk),
        .reset_i       (reset_i),
        .trace_enable_i(trace_enable_i),
        .retire_i      (retire_i),
        .resync_due_i  (gt_max),
        .map_full_i    (bmap_full_next),
        .send_o        (send),
        .fmt_o         (fmt),
        .sync_sent_o   (sync_sent)
    );

    // every packet empties the map
    trace_branch_map u_branch_map (
        .clk           (clk),
        .reset_i       (reset_i),
        .trace_enable_i(trace_enable_i),
        .retire_i      (retire_i),
        .flush_i       (send),
        .count_o       (bmap_count),
        .map_o         (bmap_bits),
        .full_next_o   (bmap_full_next)
    );

    trace_resync_counter #(
        .MODE     (RESYNC_PACKETS),
        .MAX_VALUE(`TRACE_RESYNC_MAX)
    ) u_resync_counter (
        .clk             (clk),
        .reset_i         (reset_i),
        .trace_enabled_i (trace_enable_i),
        .packet_emitted_i(send),
        .resync_rst_i    (sync_sent),
        .gt_resync_max_o (gt_max),
        .et_resync_max_o (et_max)
    );

    trace_packet_emitter u_emitter (
        .clk           (clk),
        .reset_i       (reset_i),
        .send_i        (send),
        .fmt_i         (fmt),
        .retire_i      (retire_i),
        .branches_i    (bmap_count),
        .branch_map_i  (bmap_bits),
        .packet_o      (packet_o),
        .packet_valid_o(packet_valid_o)
    );

    // one more non-sync packet at max makes a resync due
    property p_resync_due;
        @(posedge clk) disable iff (reset_i)
        (et_max && send && !sync_sent) |=> gt_max;
    endproperty

    a_resync_due: assert property (p_resync_due)
        else $error("%0t: gt_max expected 1 after packet at max, got %b", $time, gt_max);

endmodule

/* tb_clock_gen.sv */
// ========================================
// testbench clock and reset generator
// ========================================

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // reset released on a falling edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

/* tb_trace_encoder.sv */
// ========================================
// trace encoder testbench
// random retirements against a reference model
// ========================================

`timescale 1ns/1ps

`include "trace_enc_consts.svh"

module tb_trace_encoder
    import trace_enc_pkg::*;
();

    typedef enum logic [2:0] {R_NONE, R_FIRST, R_EXC, R_RESYNC, R_FULL} reason_e;

    localparam int PHASES = 48;

    logic          clk;
    logic          reset;
    logic          trace_enable;
    retire_t       retire;
    trace_packet_t packet;
    logic          packet_valid;
    integer        seed;
    int            errors;
    int            hits [5];

    // reference model state
    logic                       m_first;
    int                         m_since_sync;
    int                         m_bcnt;
    logic [`TRACE_BMAP_LEN-1:0] m_bmap;

    // expected output, one cycle ahead of the dut
    logic          exp_valid_d;
    logic          exp_valid_q;
    trace_packet_t exp_pkt_d;
    trace_packet_t exp_pkt_q;
    logic          both_valid;

    tb_clock_gen u_clock_gen (
        .clk_o  (clk),
        .reset_o(reset)
    );

    trace_encoder_top dut (
        .clk           (clk),
        .reset_i       (reset),
        .trace_enable_i(trace_enable),
        .retire_i      (retire),
        .packet_o      (packet),
        .packet_valid_o(packet_valid)
    );

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] got_v);
        errors++;
        $display("error %0t %s expected %0h got %0h", $time, name, exp_v, got_v);
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // mode 0 mixed, mode 1 branches only, mode 2 no branches
    function automatic retire_t random_retire(input int mode, input int density);
        retire_t r;
        r.valid        = (rand_below(100) < density);
        r.iaddr        = $random(seed);
        r.is_branch    = (mode == 1) || ((mode == 0) && (rand_below(2) == 0));
        r.taken        = (rand_below(2) == 1);
        r.is_exception = (mode == 0) ? (rand_below(32) == 0) :
                         (mode == 2) ? (rand_below(6) == 0) : 1'b0;
        r.cause        = `TRACE_CAUSE_W'(rand_below(32));
        return r;
    endfunction

    // expected packet for this cycle's inputs, then state after the edge
    task automatic model_step(input logic en, input retire_t r);
        logic [`TRACE_BMAP_LEN-1:0] cur_map;
        int                         cur_cnt;
        reason_e                    why;
        cur_map     = m_bmap;
        cur_cnt     = m_bcnt;
        why         = R_NONE;
        exp_valid_d = 1'b0;
        if (!en) begin
            m_first      = 1'b1;
            m_since_sync = 0;
            cur_map      = '0;
            cur_cnt      = 0;
        end else if (r.valid) begin
            if (r.is_branch) begin
                cur_map[cur_cnt] = r.taken;
                cur_cnt++;
            end
            if (m_first) begin
                why = R_FIRST;
            end else if (r.is_exception) begin
                why = R_EXC;
            end else if (m_since_sync > `TRACE_RESYNC_MAX) begin
                why = R_RESYNC;
            end else if (cur_cnt == `TRACE_BMAP_LEN) begin
                why = R_FULL;
            end
        end
        if (why != R_NONE) begin
            exp_valid_d          = 1'b1;
            exp_pkt_d.format     = (why == R_EXC) ? FMT_EXC :
                                   (why == R_FULL) ? FMT_BRANCH : FMT_SYNC;
            exp_pkt_d.address    = r.iaddr;
            exp_pkt_d.cause      = (why == R_EXC) ? r.cause : '0;
            exp_pkt_d.branches   = `TRACE_BCNT_W'(cur_cnt);
            exp_pkt_d.branch_map = cur_map;
            cur_map              = '0;
            cur_cnt              = 0;
            if (exp_pkt_d.format == FMT_SYNC) begin
                m_first      = 1'b0;
                m_since_sync = 0;
            end else if (m_since_sync <= `TRACE_RESYNC_MAX) begin
                m_since_sync++;
            end
            hits[int'(why)]++;
        end
        m_bmap = cur_map;
        m_bcnt = cur_cnt;
    endtask

    task automatic drive(input logic en, input retire_t r);
        @(negedge clk);
        trace_enable = en;
        retire       = r;
        model_step(en, r);
    endtask

    task automatic wait_reset_release(output logic released);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while ((reset !== 1'b0) && (cycles < 20));
        released = (reset === 1'b0);
    endtask

    task automatic check_reached();
        reason_e why;
        for (int i = 1; i < 5; i++) begin
            why = reason_e'(i);
            if (hits[i] == 0) begin
                errors++;
                $display("stimulus never produced a %s packet", why.name());
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            exp_valid_q <= 1'b0;
        end else begin
            exp_valid_q <= exp_valid_d;
        end
        exp_pkt_q <= exp_pkt_d;
    end

    assign both_valid = packet_valid && exp_valid_q;

    // no packet without a traced retirement in the previous cycle
    a_idle_low: assert property (@(posedge clk) disable iff (reset)
        !$past(trace_enable && retire.valid) |-> !packet_valid)
        else report_mismatch("packet_valid_o", 0, $sampled(packet_valid));

    a_valid: assert property (@(posedge clk) disable iff (reset)
        packet_valid == exp_valid_q)
        else report_mismatch("packet_valid_o", $sampled(exp_valid_q), $sampled(packet_valid));

    // covers first sync, exception and forced resync
    a_format: assert property (@(posedge clk) disable iff (reset)
        both_valid |-> (packet.format == exp_pkt_q.format))
        else report_mismatch("packet_o.format", $sampled(exp_pkt_q.format),
                             $sampled(packet.format));

    a_address: assert property (@(posedge clk) disable iff (reset)
        both_valid |-> (packet.address == exp_pkt_q.address))
        else report_mismatch("packet_o.address", $sampled(exp_pkt_q.address),
                             $sampled(packet.address));

    a_cause: assert property (@(posedge clk) disable iff (reset)
        both_valid |-> (packet.cause == exp_pkt_q.cause))
        else report_mismatch("packet_o.cause", $sampled(exp_pkt_q.cause),
                             $sampled(packet.cause));

    a_cause_zero: assert property (@(posedge clk) disable iff (reset)
        (packet_valid && (packet.format != FMT_EXC)) |-> (packet.cause == '0))
        else report_mismatch("packet_o.cause", 0, $sampled(packet.cause));

    a_full_count: assert property (@(posedge clk) disable iff (reset)
        (packet_valid && (packet.format == FMT_BRANCH)) |-> (packet.branches == 31))
        else report_mismatch("packet_o.branches", 31, $sampled(packet.branches));

    a_branches: assert property (@(posedge clk) disable iff (reset)
        both_valid |-> (packet.branches == exp_pkt_q.branches))
        else report_mismatch("packet_o.branches", $sampled(exp_pkt_q.branches),
                             $sampled(packet.branches));

    a_map: assert property (@(posedge clk) disable iff (reset)
        both_valid |-> (packet.branch_map == exp_pkt_q.branch_map))
        else report_mismatch("packet_o.branch_map", $sampled(exp_pkt_q.branch_map),
                             $sampled(packet.branch_map));

    initial begin
        logic released;
        int   mode;
        int   density;
        int   len;
        seed         = 32'h278e026d;
        errors       = 0;
        hits         = '{default: 0};
        trace_enable = 1'b0;
        retire       = '0;
        m_first      = 1'b1;
        m_since_sync = 0;
        m_bcnt       = 0;
        m_bmap       = '0;
        exp_valid_d  = 1'b0;
        exp_pkt_d    = '0;
        wait_reset_release(released);
        if (!released) begin
            $display("timeout waiting for reset to be released");
            $display("TEST FAILED");
            $finish;
        end else begin
            for (int p = 0; p < PHASES; p++) begin
                mode    = rand_below(3);
                density = 30 + rand_below(71);
                len     = 60 + rand_below(140);
                // short trace-off gap before some phases
                if (rand_below(2) == 0) begin
                    repeat (1 + rand_below(4)) drive(1'b0, random_retire(mode, density));
                end
                repeat (len) drive(1'b1, random_retire(mode, density));
            end
            // drain the last packet through the checks
            repeat (2) drive(1'b0, '0);
            check_reached();
            $display("checks done, %0d errors", errors);
            if (errors == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

/* trace_encoder.f */
+incdir+.
trace_enc_pkg.sv
trace_resync_counter.sv
trace_branch_map.sv
trace_packet_decider.sv
trace_packet_emitter.sv
trace_encoder_top.sv
tb_clock_gen.sv
tb_trace_encoder.sv

/* Bender.yml */
package:
  name: trace_encoder

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - trace_enc_pkg.sv
      - trace_resync_counter.sv
      - trace_branch_map.sv
      - trace_packet_decider.sv
      - trace_packet_emitter.sv
      - trace_encoder_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_trace_encoder.sv
